//--- kclk_consts.svh
`ifndef KCLK_CONSTS_SVH
`define KCLK_CONSTS_SVH

// sample path
`define KCLK_WIDTH 16

// fraction output is one bit wider than this
`define KCLK_FRAC_BITS 15

//////////////////////////////
// sample buffer
//////////////////////////////

`define KCLK_FIFO_DEPTH 2048
`define KCLK_PTR_BITS 11

//////////////////////////////
// threshold calibration
//////////////////////////////

`define KCLK_CALIB_SAMPLES 500
`define KCLK_CALIB_CNT_BITS 10

`endif

//--- kclk_pkg.sv
package kclk_pkg;

`include "kclk_consts.svh"

    // raw sample, also used for threshold and divider operands
    typedef logic [`KCLK_WIDTH-1:0] sample_t;

    // rounded sub-sample position
    typedef logic [`KCLK_FRAC_BITS:0] frac_t;

    // raw quotient, one guard bit below the result
    typedef logic [`KCLK_FRAC_BITS+1:0] quot_t;

    typedef logic [`KCLK_PTR_BITS-1:0] fifo_ptr_t;

    typedef logic [`KCLK_CALIB_CNT_BITS-1:0] calib_cnt_t;

    typedef enum logic [1:0] {
        CALIB,
        MEAN_LOAD,
        RUN
    } ctrl_state_t;

endpackage

//--- kclk_ctrl.sv
`include "kclk_consts.svh"

module kclk_ctrl import kclk_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic i_valid,
    output logic o_stats_en,
    output logic o_mean_load,
    output logic o_rd_en
);

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    calib_cnt_t  calib_cnt;
    logic        last_calib;

    // 500th valid sample during calibration
    assign last_calib = (state == CALIB) && i_valid &&
                        (calib_cnt == calib_cnt_t'(`KCLK_CALIB_SAMPLES - 1));

    always_comb begin
        state_nxt = state;
        case (state)
            CALIB: begin
                if (last_calib) begin
                    state_nxt = MEAN_LOAD;
                end
            end
            MEAN_LOAD: state_nxt = RUN;
            RUN:       state_nxt = RUN;
            default:   state_nxt = CALIB;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= CALIB;
            calib_cnt <= '0;
        end else begin
            state <= state_nxt;
            // count only samples that go into min/max
            if (o_stats_en) begin
                calib_cnt <= calib_cnt + 1'b1;
            end
        end
    end

    assign o_stats_en  = (state == CALIB) && i_valid;
    assign o_mean_load = (state == MEAN_LOAD);
    // drain stays on once running
    assign o_rd_en     = (state == RUN);

endmodule

//--- level_stats.sv
`include "kclk_consts.svh"

module level_stats import kclk_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  sample_t i_data,
    input  logic    i_stats_en,
    input  logic    i_mean_load,
    output sample_t o_mean
);

    sample_t              min_val;
    sample_t              max_val;
    logic [`KCLK_WIDTH:0] sum_val;

    //////////////////////////////
    // running extremes
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            min_val <= '1;
            max_val <= '0;
        end else if (i_stats_en) begin
            if (i_data < min_val) begin
                min_val <= i_data;
            end
            if (i_data > max_val) begin
                max_val <= i_data;
            end
        end
    end

    //////////////////////////////
    // midpoint threshold
    //////////////////////////////

    // extra bit keeps the carry
    assign sum_val = {1'b0, min_val} + {1'b0, max_val};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_mean <= '0;
        end else if (i_mean_load) begin
            // floor of the midpoint
            o_mean <= sum_val[`KCLK_WIDTH:1];
        end
    end

endmodule

//--- sample_fifo.sv
`include "kclk_consts.svh"

module sample_fifo import kclk_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  sample_t i_wr_data,
    input  logic    i_wr_en,
    input  logic    i_rd_en,
    output sample_t o_rd_data,
    output logic    o_rd_valid
);

    sample_t                mem [0:`KCLK_FIFO_DEPTH-1];
    fifo_ptr_t              wr_ptr;
    fifo_ptr_t              rd_ptr;
    logic [`KCLK_PTR_BITS:0] count;
    logic                   full;
    logic                   empty;
    logic                   wr_ok;
    logic                   rd_ok;

    assign full  = (count == (`KCLK_PTR_BITS+1)'(`KCLK_FIFO_DEPTH));
    assign empty = (count == '0);

    // writes while full are lost
    assign wr_ok = i_wr_en && !full;
    assign rd_ok = i_rd_en && !empty;

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_ptr] <= i_wr_data;
        end
        if (rd_ok) begin
            o_rd_data <= mem[rd_ptr];
        end
    end

    // pointers wrap on their own at the full depth
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            o_rd_valid <= 1'b0;
        end else begin
            o_rd_valid <= rd_ok;
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_ok, rd_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- crossing_detector.sv
module crossing_detector import kclk_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  sample_t i_sample,
    input  logic    i_sample_valid,
    input  sample_t i_mean,
    output sample_t o_num,
    output sample_t o_den,
    output logic    o_cross_valid
);

    sample_t prev_sample;
    logic    have_prev;
    logic    falling;

    // below threshold now, at or above it before
    assign falling = i_sample_valid && have_prev &&
                     (i_sample < i_mean) && (prev_sample >= i_mean);

    //////////////////////////////
    // previous sample
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (i_sample_valid) begin
            prev_sample <= i_sample;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            have_prev <= 1'b0;
        end else if (i_sample_valid) begin
            have_prev <= 1'b1;
        end
    end

    //////////////////////////////
    // divider operands
    //////////////////////////////

    // num < den and den > 0 follow from the test above
    always_ff @(posedge clk) begin
        if (falling) begin
            o_num <= prev_sample - i_mean;
            o_den <= prev_sample - i_sample;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_cross_valid <= 1'b0;
        end else begin
            o_cross_valid <= falling;
        end
    end

endmodule

//--- fraction_divider.sv
`include "kclk_consts.svh"

module fraction_divider import kclk_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  sample_t i_num,
    input  sample_t i_den,
    input  logic    i_valid,
    output frac_t   o_frac,
    output logic    o_valid
);

    // one quotient bit per stage, plus the guard bit
    localparam int STAGES = `KCLK_FRAC_BITS + 1;

    // index 0 is the input stage
    sample_t           rem_q [0:STAGES-1];
    sample_t           den_q [0:STAGES-1];
    quot_t             quo_q [1:STAGES];
    logic [STAGES:0]   vld_q;

    sample_t           rem_d [1:STAGES];
    quot_t             quo_d [1:STAGES];

    //////////////////////////////
    // restoring stages
    //////////////////////////////

    always_comb begin : trial_sub
        logic [`KCLK_WIDTH:0] shifted;
        logic [`KCLK_WIDTH:0] diff;
        quot_t                quo_prev;
        // first stage starts from an empty quotient
        quo_prev = '0;
        for (int k = 1; k <= STAGES; k++) begin
            shifted = {rem_q[k-1], 1'b0};
            diff    = shifted - {1'b0, den_q[k-1]};
            // no borrow means the divisor fits
            if (!diff[`KCLK_WIDTH]) begin
                rem_d[k] = diff[`KCLK_WIDTH-1:0];
                quo_d[k] = {quo_prev[`KCLK_WIDTH-1:0], 1'b1};
            end else begin
                rem_d[k] = shifted[`KCLK_WIDTH-1:0];
                quo_d[k] = {quo_prev[`KCLK_WIDTH-1:0], 1'b0};
            end
            quo_prev = quo_q[k];
        end
    end

    always_ff @(posedge clk) begin
        rem_q[0] <= i_num;
        den_q[0] <= i_den;
        for (int k = 1; k < STAGES; k++) begin
            rem_q[k] <= rem_d[k];
            den_q[k] <= den_q[k-1];
        end
        for (int k = 1; k <= STAGES; k++) begin
            quo_q[k] <= quo_d[k];
        end
        // round half up on the guard bit
        o_frac <= quo_q[STAGES][`KCLK_WIDTH:1] + frac_t'(quo_q[STAGES][0]);
    end

    //////////////////////////////
    // valid shift
    //////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q   <= '0;
            o_valid <= 1'b0;
        end else begin
            vld_q   <= {vld_q[STAGES-1:0], i_valid};
            o_valid <= vld_q[STAGES];
        end
    end

endmodule

//--- kclk_top.sv
module kclk_top import kclk_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  sample_t i_data,
    input  logic    i_valid,
    output frac_t   o_data,
    output logic    o_trigger
);

    sample_t data_r;
    logic    valid_r;
    logic    stats_en;
    logic    mean_load;
    logic    rd_en;
    sample_t mean;
    sample_t fifo_data;
    logic    fifo_valid;
    sample_t num;
    sample_t den;
    logic    cross_valid;
    frac_t   frac;
    logic    frac_valid;

    //////////////////////////////
    // input register
    //////////////////////////////

    always_ff @(posedge clk) begin
        data_r <= i_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_r <= 1'b0;
        end else begin
            valid_r <= i_valid;
        end
    end

    kclk_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_valid    (valid_r),
        .o_stats_en (stats_en),
        .o_mean_load(mean_load),
        .o_rd_en    (rd_en)
    );

    level_stats u_stats (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_data     (data_r),
        .i_stats_en (stats_en),
        .i_mean_load(mean_load),
        .o_mean     (mean)
    );

    // every sample is queued, calibration ones too
    sample_fifo u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_wr_data (data_r),
        .i_wr_en   (valid_r),
        .i_rd_en   (rd_en),
        .o_rd_data (fifo_data),
        .o_rd_valid(fifo_valid)
    );

    crossing_detector u_detect (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_sample      (fifo_data),
        .i_sample_valid(fifo_valid),
        .i_mean        (mean),
        .o_num         (num),
        .o_den         (den),
        .o_cross_valid (cross_valid)
    );

    fraction_divider u_div (
        .clk    (clk),
        .rst_n  (rst_n),
        .i_num  (num),
        .i_den  (den),
        .i_valid(cross_valid),
        .o_frac (frac),
        .o_valid(frac_valid)
    );

    //////////////////////////////
    // output register
    //////////////////////////////

    // data is zero outside a trigger
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_trigger <= 1'b0;
            o_data    <= '0;
        end else begin
            o_trigger <= frac_valid;
            o_data    <= frac_valid ? frac : '0;
        end
    end

endmodule

//--- tb_kclk.sv
`include "kclk_consts.svh"

module tb_kclk import kclk_pkg::*; ();

    localparam int N_SAMPLES      = 3000;
    localparam int TIMEOUT_CYCLES = 3 * N_SAMPLES + `KCLK_FIFO_DEPTH + 100;
    // divider latency plus detector and output registers, with margin
    localparam int SETTLE_CYCLES  = `KCLK_FRAC_BITS + 3 + 16;

    logic    clk;
    logic    rst_n;
    sample_t i_data;
    logic    i_valid;
    frac_t   o_data;
    logic    o_trigger;

    logic [15:0] lfsr_state = 16'd6539;
    sample_t     samples [0:N_SAMPLES-1];
    int          gaps [0:N_SAMPLES-1];
    frac_t       exp_q [$];
    int          model_count   = 0;
    int          trig_count    = 0;
    int          applied_count = 0;
    int          cycles        = 0;
    int          errors        = 0;

    kclk_top dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_data   (i_data),
        .i_valid  (i_valid),
        .o_data   (o_data),
        .o_trigger(o_trigger)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    //////////////////////////////
    // random source
    //////////////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("Fail at time %0t: %s expected %0h got %0h", $time, name, expected, actual);
        end
    endtask

    //////////////////////////////
    // stimulus and model
    //////////////////////////////

    // triangle wave with random slopes and turn points, plus small jitter
    task automatic build_stimulus();
        int          level;
        int          upper;
        int          lower;
        int          step;
        int          jitter;
        logic        going_up;
        logic [15:0] r;
        level    = 32'h8000;
        going_up = 1'b1;
        upper    = 32'hC000 + int'(rand_bits(12));
        lower    = 32'h3000 + int'(rand_bits(12));
        for (int i = 0; i < N_SAMPLES; i++) begin
            step = 128 + int'(rand_bits(10));
            if (going_up) begin
                level = level + step;
                if (level >= upper) begin
                    level    = upper;
                    going_up = 1'b0;
                    lower    = 32'h3000 + int'(rand_bits(12));
                end
            end else begin
                level = level - step;
                if (level <= lower) begin
                    level    = lower;
                    going_up = 1'b1;
                    upper    = 32'hC000 + int'(rand_bits(12));
                end
            end
            jitter     = int'(rand_bits(8)) - 128;
            samples[i] = 16'(level + jitter);
            r          = rand_bits(2);
            gaps[i]    = (r[1] ^ r[0]) ? 2 : 1;
        end
    endtask

    // midpoint threshold, then falling crossings with rounded fractions
    task automatic build_model();
        int      mn;
        int      mx;
        int      thr;
        int      num;
        int      den;
        longint  q;
        mn = 32'hFFFF;
        mx = 0;
        for (int i = 0; i < `KCLK_CALIB_SAMPLES; i++) begin
            if (int'(samples[i]) < mn) begin
                mn = int'(samples[i]);
            end
            if (int'(samples[i]) > mx) begin
                mx = int'(samples[i]);
            end
        end
        thr = (mn + mx) / 2;
        // first sample has no predecessor
        for (int i = 1; i < N_SAMPLES; i++) begin
            if ((int'(samples[i]) < thr) && (int'(samples[i-1]) >= thr)) begin
                num = int'(samples[i-1]) - thr;
                den = int'(samples[i-1]) - int'(samples[i]);
                q   = (longint'(num) * 65536) / longint'(den);
                exp_q.push_back(16'((q / 2) + (q % 2)));
                model_count++;
            end
        end
        $display("model: threshold %0h, %0d falling crossings", thr, model_count);
    endtask

    //////////////////////////////
    // output monitor
    //////////////////////////////

    always @(posedge clk) begin
        if (rst_n && i_valid) begin
            applied_count++;
        end
    end

    always @(negedge clk) begin
        if (o_trigger === 1'b1) begin
            trig_count++;
            if (applied_count < `KCLK_CALIB_SAMPLES) begin
                errors++;
                $display("trigger at time %0t came before calibration finished", $time);
            end
            if (exp_q.size() == 0) begin
                errors++;
                $display("trigger at time %0t with no crossing left in the model", $time);
            end else begin
                check_value("o_data", 32'(exp_q.pop_front()), 32'(o_data));
            end
        end else begin
            check_value("o_data", 32'h0, 32'(o_data));
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            errors++;
            $display("timeout after %0d cycles, the DUT did not deliver all results", cycles);
            $display("errors: %0d, triggers: %0d of %0d expected",
                     errors, trig_count, model_count);
            $display("TESTS FAILED");
            $finish;
        end
    end

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        rst_n   = 1'b0;
        i_data  = '0;
        i_valid = 1'b0;
        build_stimulus();
        build_model();

        repeat (8) begin
            @(negedge clk);
            check_value("o_trigger", 32'h0, 32'(o_trigger));
            check_value("o_data", 32'h0, 32'(o_data));
        end
        rst_n = 1'b1;

        for (int k = 0; k < N_SAMPLES; k++) begin
            @(negedge clk);
            i_data  = samples[k];
            i_valid = 1'b1;
            repeat (gaps[k]) begin
                @(negedge clk);
                i_valid = 1'b0;
                // junk data while idle
                i_data  = ~samples[k];
            end
        end

        while (trig_count < model_count) begin
            @(posedge clk);
        end
        // catch any extra trigger still in the pipeline
        repeat (SETTLE_CYCLES) @(posedge clk);

        check_value("trigger count", 32'(model_count), 32'(trig_count));

        $display("errors: %0d, triggers: %0d of %0d expected",
                 errors, trig_count, model_count);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- kclk_top.f
+incdir+.
kclk_pkg.sv
kclk_ctrl.sv
level_stats.sv
sample_fifo.sv
crossing_detector.sv
fraction_divider.sv
kclk_top.sv
tb_kclk.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the k-clock testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f kclk_top.f --top-module tb_kclk -o sim_kclk

./obj_dir/sim_kclk > sim.log
cat sim.log

if grep -qx "TESTS PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
